// ==== emu_pi.f ====
+incdir+verif
verilog/emu_pkg.sv
verilog/osc_model.sv
verilog/jitter_gen.sv
verilog/clk_delay_core.sv
verilog/phase_interpolator.sv
verilog/dt_arbiter.sv
verilog/emu_top.sv
verif/tb_emu_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -f emu_pi.f --top-module tb_emu_top

if ! sim_out="$(./obj_dir/Vtb_emu_top 2>&1)"; then
    echo "$sim_out"
    echo "simulation exited with an error status"
    exit 1
fi
echo "$sim_out"

if grep -q "ALL TESTS PASSED" <<< "$sim_out"; then
    exit 0
fi
exit 1

// ==== verif/emu_model.svh ====
`ifndef EMU_MODEL_SVH
`define EMU_MODEL_SVH

// one predicted transition of clk_out_slice, times in ps
typedef struct packed {
    longint edge_time;
    longint nominal;
    logic   level;
} exp_edge_t;

logic [31:0]    model_lfsr;
emu_pkg::code_t model_code;
exp_edge_t      exp_q[$];

function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x;
    y = y ^ (y << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
endfunction

// galois form, shifting right with the mask folded in on a one
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0]) begin
        n = n ^ emu_pkg::LFSR_TAPS;
    end
    return n;
endfunction

// low bits of the state centred on zero
function automatic int jitter_of(input logic [31:0] s, input logic en);
    int low;
    low = int'(s % JITTER_SPAN);
    if (!en) begin
        return 0;
    end
    return low - JITTER_SPAN / 2;
endfunction

function automatic int nominal_delay(input emu_pkg::code_t c);
    return OFFSET_PS + int'(c) * STEP_PS;
endfunction

task automatic model_reset();
    model_lfsr = 32'h1;
    model_code = '0;
    exp_q.delete();
endtask

// input edge at t_in becomes one expected output edge
task automatic predict_output_edge(input longint t_in, input logic level, input logic en);
    exp_edge_t e;
    e.nominal   = t_in + longint'(nominal_delay(model_code));
    e.edge_time = e.nominal + longint'(jitter_of(model_lfsr, en));
    e.level     = level;
    exp_q.push_back(e);
endtask

// the seed load wins over the LFSR step of the same cycle
task automatic update_model(input logic strobe, input logic valid,
                            input emu_pkg::code_t c, input logic [31:0] seed);
    if (valid) begin
        model_code = c;
        model_lfsr = (seed == 32'h0) ? 32'h1 : seed;
    end else if (strobe) begin
        model_lfsr = lfsr_step(model_lfsr);
    end
endtask

`endif

// ==== verif/tb_emu_top.sv ====
`timescale 1ns/1ps

module tb_emu_top;

    localparam int STEP_PS         = 2;
    localparam int OFFSET_PS       = 100;
    localparam int JITTER_SPAN     = 32;
    localparam int QUEUE_DEPTH     = 4;
    localparam int CLK_PERIOD      = 20;
    localparam int RST_CYCLES      = 5;
    localparam int EDGES_PER_PHASE = 400;
    // every cycle ends on an input toggle or an output edge
    // a half period above DT_MAX adds one capped step per input edge
    localparam int RUN_CYCLES      = 4 * EDGES_PER_PHASE * 2 + EDGES_PER_PHASE
                                   + RST_CYCLES + 16;
    localparam int WATCHDOG_CYCLES = RUN_CYCLES * 3 / 2;

    typedef enum int {PH_OSC, PH_FIXED, PH_CODE, PH_JITTER} phase_t;

    logic           emu_clk;
    logic           rst_n;
    emu_pkg::dt_t   half_period;
    logic           ctl_valid;
    emu_pkg::code_t ctl;
    logic [31:0]    jitter_seed;
    logic           jitter_en;
    logic           clk_in;
    logic           clk_out_slice;
    emu_pkg::dt_t   emu_dt;

    `include "emu_model.svh"

    longint       emu_time;
    longint       exp_in_time;
    emu_pkg::dt_t hp_prev;
    logic         in_prev;
    logic         out_prev;
    logic         started;
    int           in_count;
    int           out_count;
    int           error_count;
    logic [31:0]  rnd;

    emu_top #(
        .STEP_PS    (STEP_PS),
        .OFFSET_PS  (OFFSET_PS),
        .JITTER_SPAN(JITTER_SPAN),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) uut (
        .emu_clk      (emu_clk),
        .rst_n        (rst_n),
        .half_period  (half_period),
        .ctl_valid    (ctl_valid),
        .ctl          (ctl),
        .jitter_seed  (jitter_seed),
        .jitter_en    (jitter_en),
        .clk_in       (clk_in),
        .clk_out_slice(clk_out_slice),
        .emu_dt       (emu_dt)
    );

    initial begin
        emu_clk = 1'b0;
        forever #(CLK_PERIOD / 2) emu_clk = ~emu_clk;
    end

    task automatic abort_run();
        error_count++;
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog expired with %0d input and %0d output edges seen",
                 in_count, out_count);
        abort_run();
    end

    function automatic logic [31:0] next_rand();
        rnd = xorshift32(rnd);
        return rnd;
    endfunction

    // code sweeps need a half period above the widest delay swing
    function automatic emu_pkg::dt_t pick_half_period(input phase_t ph);
        logic [31:0] r;
        r = next_rand();
        if (ph == PH_CODE) begin
            return emu_pkg::dt_t'(1200 + r % 1024);
        end
        // now and then the oscillator alone asks for more than DT_MAX
        if (ph == PH_OSC && r[31:28] == 4'h0) begin
            return emu_pkg::DT_MAX + emu_pkg::dt_t'(400 + r % 512);
        end
        return emu_pkg::dt_t'(400 + r % 512);
    endfunction

    task automatic check_output_edge();
        exp_edge_t e;
        longint    dev;
        assert (exp_q.size() > 0) else begin
            $display("clk_out_slice toggled at %0t with no input edge pending", $time);
            abort_run();
        end
        e   = exp_q.pop_front();
        dev = emu_time - e.nominal;
        assert (dev >= -longint'(JITTER_SPAN / 2) && dev < longint'(JITTER_SPAN / 2)) else begin
            $display("clk_out_slice edge at %0t is %0d ps off nominal, outside the jitter span",
                     $time, dev);
            abort_run();
        end
        assert (emu_time == e.edge_time) else begin
            $display("Mismatch at %0t: clk_out_slice edge time expected %0d ps got %0d ps",
                     $time, e.edge_time, emu_time);
            abort_run();
        end
        assert (clk_out_slice == e.level) else begin
            $display("Mismatch at %0t: clk_out_slice expected %0b got %0b",
                     $time, e.level, clk_out_slice);
            abort_run();
        end
    endtask

    // outputs are stable at the falling edge, emu_dt is the step now taken
    always @(negedge emu_clk) begin
        if (rst_n) begin
            if (!started) begin
                // first half period is sampled in the first cycle out of reset
                started     = 1'b1;
                exp_in_time = longint'(half_period);
            end
            assert (emu_dt != '0 && emu_dt <= emu_pkg::DT_MAX) else begin
                $display("Mismatch at %0t: emu_dt expected 1 to %0d got %0d",
                         $time, emu_pkg::DT_MAX, emu_dt);
                abort_run();
            end
            if (clk_out_slice !== out_prev) begin
                check_output_edge();
                out_count++;
            end
            if (clk_in !== in_prev) begin
                assert (emu_time == exp_in_time) else begin
                    $display("Mismatch at %0t: clk_in edge time expected %0d ps got %0d ps",
                             $time, exp_in_time, emu_time);
                    abort_run();
                end
                // reload took the half period of the toggle cycle
                exp_in_time = emu_time + longint'(hp_prev);
                predict_output_edge(emu_time, clk_in, jitter_en);
                in_count++;
            end
            if (exp_q.size() > 0) begin
                assert (exp_q[0].edge_time >= emu_time + longint'(emu_dt)) else begin
                    $display("step at %0t runs past the output edge due at %0d ps",
                             $time, exp_q[0].edge_time);
                    abort_run();
                end
            end
            update_model(clk_in !== in_prev, ctl_valid, ctl, jitter_seed);
            in_prev  = clk_in;
            out_prev = clk_out_slice;
            hp_prev  = half_period;
            emu_time = emu_time + longint'(emu_dt);
        end
    end

    task automatic run_phase(input phase_t ph);
        int first;
        first = in_count;
        @(posedge emu_clk);
        half_period <= pick_half_period(ph);
        jitter_en   <= (ph == PH_JITTER);
        if (ph == PH_FIXED || ph == PH_JITTER) begin
            ctl_valid   <= 1'b1;
            ctl         <= emu_pkg::code_t'(next_rand());
            jitter_seed <= next_rand();
        end
        while (in_count - first < EDGES_PER_PHASE) begin
            @(posedge emu_clk);
            ctl_valid <= 1'b0;
            if (next_rand() % 8 == 0) begin
                half_period <= pick_half_period(ph);
            end
            // code changes wait until the long half period is in effect
            if (ph == PH_CODE && in_count - first >= 2 && next_rand() % 4 == 0) begin
                ctl_valid   <= 1'b1;
                ctl         <= emu_pkg::code_t'(next_rand());
                jitter_seed <= next_rand();
            end
        end
    endtask

    initial begin
        int target;
        rst_n       = 1'b0;
        half_period = 24'd500;
        ctl_valid   = 1'b0;
        ctl         = '0;
        jitter_seed = '0;
        jitter_en   = 1'b0;
        rnd         = 32'hbae3894d;
        emu_time    = 0;
        exp_in_time = 0;
        hp_prev     = '0;
        in_prev     = 1'b0;
        out_prev    = 1'b0;
        started     = 1'b0;
        in_count    = 0;
        out_count   = 0;
        error_count = 0;
        model_reset();
        repeat (RST_CYCLES) @(posedge emu_clk);
        rst_n <= 1'b1;
        run_phase(PH_OSC);
        run_phase(PH_FIXED);
        run_phase(PH_CODE);
        run_phase(PH_JITTER);
        @(posedge emu_clk);
        ctl_valid <= 1'b0;
        // every input edge seen so far has to reach the output
        target = in_count;
        while (out_count < target) begin
            @(posedge emu_clk);
        end
        @(negedge emu_clk);
        if (error_count == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            abort_run();
        end
    end

endmodule

// ==== verilog/emu_top.sv ====
`timescale 1ns/1ps

module emu_top #(
    parameter int STEP_PS     = 2,
    parameter int OFFSET_PS   = 100,
    parameter int JITTER_SPAN = 32,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic           emu_clk,
    input  logic           rst_n,
    input  emu_pkg::dt_t   half_period,
    input  logic           ctl_valid,
    input  emu_pkg::code_t ctl,
    input  logic [31:0]    jitter_seed,
    input  logic           jitter_en,
    output logic           clk_in,
    output logic           clk_out_slice,
    output emu_pkg::dt_t   emu_dt
);

    // step requests into the arbiter
    emu_pkg::dt_t req_osc;
    emu_pkg::dt_t req_pi;

    osc_model osc_model_i (
        .emu_clk    (emu_clk),
        .rst_n      (rst_n),
        .half_period(half_period),
        .emu_dt     (emu_dt),
        .clk_val    (clk_in),
        .dt_req     (req_osc)
    );

    phase_interpolator #(
        .STEP_PS    (STEP_PS),
        .OFFSET_PS  (OFFSET_PS),
        .JITTER_SPAN(JITTER_SPAN),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) phase_interpolator_i (
        .emu_clk      (emu_clk),
        .rst_n        (rst_n),
        .ctl_valid    (ctl_valid),
        .ctl          (ctl),
        .jitter_seed  (jitter_seed),
        .jitter_en    (jitter_en),
        .clk_in       (clk_in),
        .emu_dt       (emu_dt),
        .clk_out_slice(clk_out_slice),
        .dt_req       (req_pi)
    );

    // the shared step goes back to every time-based block
    dt_arbiter dt_arbiter_i (
        .req_osc(req_osc),
        .req_pi (req_pi),
        .emu_dt (emu_dt)
    );

endmodule

// ==== verilog/dt_arbiter.sv ====
`timescale 1ns/1ps

module dt_arbiter (
    input  emu_pkg::dt_t req_osc,
    input  emu_pkg::dt_t req_pi,
    output emu_pkg::dt_t emu_dt
);

    emu_pkg::dt_t req_min;

    // smallest request wins so no block misses its next event
    assign req_min = (req_osc < req_pi) ? req_osc : req_pi;

    // idle blocks ask for DT_MAX, cap anything above it
    assign emu_dt = (req_min < emu_pkg::DT_MAX) ? req_min : emu_pkg::DT_MAX;

    // both requesters must keep time moving
    always_comb begin
        step_nonzero: assert final ($isunknown(emu_dt) || (emu_dt != '0))
            else $error("dt_arbiter: zero timestep, req_osc=%0d req_pi=%0d",
                        req_osc, req_pi);
    end

endmodule

// ==== verilog/phase_interpolator.sv ====
`timescale 1ns/1ps

module phase_interpolator #(
    parameter int STEP_PS     = 2,
    parameter int OFFSET_PS   = 100,
    parameter int JITTER_SPAN = 32,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic           emu_clk,
    input  logic           rst_n,
    input  logic           ctl_valid,
    input  emu_pkg::code_t ctl,
    input  logic [31:0]    jitter_seed,
    input  logic           jitter_en,
    input  logic           clk_in,
    input  emu_pkg::dt_t   emu_dt,
    output logic           clk_out_slice,
    output emu_pkg::dt_t   dt_req
);

    emu_pkg::code_t code_q;
    emu_pkg::jit_t  jitter;
    logic           edge_strobe;

    // delays must stay positive for the most negative jitter
    if (OFFSET_PS < JITTER_SPAN / 2 + 1) begin : g_offset_check
        $error("phase_interpolator: OFFSET_PS too small for JITTER_SPAN");
    end

    // code takes effect for edges detected from the next cycle on
    always_ff @(posedge emu_clk or negedge rst_n) begin
        if (!rst_n) begin
            code_q <= '0;
        end else if (ctl_valid) begin
            code_q <= ctl;
        end
    end

    // seed is reloaded on the same strobe as the code
    jitter_gen #(
        .JITTER_SPAN(JITTER_SPAN)
    ) jitter_gen_i (
        .emu_clk  (emu_clk),
        .rst_n    (rst_n),
        .seed_load(ctl_valid),
        .seed     (jitter_seed),
        .step     (edge_strobe),
        .jitter_en(jitter_en),
        .jitter   (jitter)
    );

    clk_delay_core #(
        .STEP_PS    (STEP_PS),
        .OFFSET_PS  (OFFSET_PS),
        .QUEUE_DEPTH(QUEUE_DEPTH)
    ) clk_delay_core_i (
        .emu_clk    (emu_clk),
        .rst_n      (rst_n),
        .code       (code_q),
        .jitter     (jitter),
        .clk_i_val  (clk_in),
        .emu_dt     (emu_dt),
        .clk_o_val  (clk_out_slice),
        .edge_strobe(edge_strobe),
        .dt_req     (dt_req)
    );

endmodule

// ==== verilog/clk_delay_core.sv ====
`timescale 1ns/1ps

module clk_delay_core #(
    parameter int STEP_PS     = 2,
    parameter int OFFSET_PS   = 100,
    parameter int QUEUE_DEPTH = 4
) (
    input  logic           emu_clk,
    input  logic           rst_n,
    input  emu_pkg::code_t code,
    input  emu_pkg::jit_t  jitter,
    input  logic           clk_i_val,
    input  emu_pkg::dt_t   emu_dt,
    output logic           clk_o_val,
    output logic           edge_strobe,
    output emu_pkg::dt_t   dt_req
);

    // count width also covers a push on top of a full queue
    localparam int CW = $clog2(QUEUE_DEPTH + 2);
    localparam logic [CW-1:0] DEPTH = CW'(QUEUE_DEPTH);

    logic               clk_prev;
    emu_pkg::edge_evt_t q [QUEUE_DEPTH];
    logic [CW-1:0]      count;
    emu_pkg::dt_t       new_delay;
    emu_pkg::dt_t       pend_sum;
    emu_pkg::edge_evt_t ext [QUEUE_DEPTH+1];
    logic [CW-1:0]      ext_count;
    logic               head_fire;
    emu_pkg::edge_evt_t q_next [QUEUE_DEPTH];
    logic [CW-1:0]      count_next;

    // input transition seen one cycle after the oscillator toggled
    assign edge_strobe = (clk_i_val != clk_prev);

    // total delay of this edge, jitter sign extended
    assign new_delay = emu_pkg::dt_t'(OFFSET_PS)
                     + emu_pkg::dt_t'(code) * emu_pkg::dt_t'(STEP_PS)
                     + emu_pkg::dt_t'(jitter);

    // absolute time until the last pending edge
    always_comb begin
        pend_sum = '0;
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            if (i < int'(count)) begin
                pend_sum = pend_sum + q[i].remaining;
            end
        end
    end

    // queue as seen during this cycle, new edge appended behind the tail
    always_comb begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            ext[i] = q[i];
        end
        ext[QUEUE_DEPTH] = '0;
        ext_count = count;
        if (edge_strobe) begin
            ext[count] = '{level: clk_i_val, remaining: new_delay - pend_sum};
            ext_count  = count + 1'b1;
        end
    end

    // the delay of a fresh edge already counts down in its detection cycle
    assign dt_req    = (ext_count != '0) ? ext[0].remaining : emu_pkg::DT_MAX;
    assign head_fire = (ext_count != '0) && (ext[0].remaining == emu_dt);

    // only the head counts down, the rest keep their relative times
    always_comb begin
        for (int i = 0; i < QUEUE_DEPTH; i++) begin
            q_next[i] = head_fire ? ext[i+1] : ext[i];
        end
        if (!head_fire) begin
            q_next[0].remaining = ext[0].remaining - emu_dt;
        end
        count_next = head_fire ? ext_count - 1'b1 : ext_count;
        // clamp so the count stays a legal queue index
        if (count_next > DEPTH) begin
            count_next = DEPTH;
        end
    end

    always_ff @(posedge emu_clk or negedge rst_n) begin
        if (!rst_n) begin
            clk_prev  <= 1'b0;
            clk_o_val <= 1'b0;
            count     <= '0;
        end else begin
            clk_prev <= clk_i_val;
            count    <= count_next;
            if (head_fire) begin
                clk_o_val <= ext[0].level;
            end
        end
    end

    always_ff @(posedge emu_clk) begin
        q <= q_next;
    end

    // a full queue only takes a new edge when the head leaves in the same cycle
    no_overflow: assert property (
        @(posedge emu_clk) disable iff (!rst_n)
        (edge_strobe && (count == DEPTH)) |-> head_fire
    );

    // output edges keep input order, strictly after the last one queued
    edge_order: assert property (
        @(posedge emu_clk) disable iff (!rst_n)
        edge_strobe |-> (new_delay > pend_sum)
    );

    // a zero request would stall emulated time
    req_nonzero: assert property (
        @(posedge emu_clk) disable iff (!rst_n)
        dt_req != '0
    );

endmodule

// ==== verilog/jitter_gen.sv ====
`timescale 1ns/1ps

module jitter_gen #(
    parameter int JITTER_SPAN = 32
) (
    input  logic          emu_clk,
    input  logic          rst_n,
    input  logic          seed_load,
    input  logic [31:0]   seed,
    input  logic          step,
    input  logic          jitter_en,
    output emu_pkg::jit_t jitter
);

    localparam int JW = $clog2(JITTER_SPAN);
    localparam emu_pkg::jit_t HALF_SPAN = emu_pkg::jit_t'(JITTER_SPAN / 2);

    logic [31:0]   state;
    logic [31:0]   state_next;
    emu_pkg::jit_t raw;

    // shift right, fold the mask in when bit 0 falls out
    assign state_next = (state >> 1) ^ (state[0] ? emu_pkg::LFSR_TAPS : 32'h0);

    // low bits taken as unsigned, then centred around zero
    assign raw    = emu_pkg::jit_t'(state[JW-1:0]);
    assign jitter = jitter_en ? raw - HALF_SPAN : '0;

    always_ff @(posedge emu_clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= 32'h1;
        end else if (seed_load) begin
            // all-zero state would lock the LFSR
            state <= (seed == 32'h0) ? 32'h1 : seed;
        end else if (step) begin
            state <= state_next;
        end
    end

    // the sequence must never reach the lock-up state
    state_nonzero: assert property (
        @(posedge emu_clk) disable iff (!rst_n)
        state != '0
    );

endmodule

// ==== verilog/osc_model.sv ====
`timescale 1ns/1ps

module osc_model (
    input  logic         emu_clk,
    input  logic         rst_n,
    input  emu_pkg::dt_t half_period,
    input  emu_pkg::dt_t emu_dt,
    output logic         clk_val,
    output emu_pkg::dt_t dt_req
);

    emu_pkg::dt_t remaining;
    logic         armed;
    emu_pkg::dt_t cur_rem;
    logic         toggle;
    logic         reload;

    // straight after reset the count is a full half period
    assign cur_rem = armed ? remaining : half_period;

    // toggle lands exactly on the end of this step
    assign toggle = (cur_rem == emu_dt);

    // cycles in which half_period is sampled
    assign reload = toggle || !armed;

    // never step past the next toggle
    assign dt_req = cur_rem;

    always_ff @(posedge emu_clk or negedge rst_n) begin
        if (!rst_n) begin
            armed     <= 1'b0;
            clk_val   <= 1'b0;
            remaining <= '0;
        end else begin
            armed <= 1'b1;
            if (toggle) begin
                clk_val   <= ~clk_val;
                remaining <= half_period;
            end else begin
                remaining <= cur_rem - emu_dt;
            end
        end
    end

    // a zero half period would request a zero step after the reload
    half_period_nonzero: assert property (
        @(posedge emu_clk) disable iff (!rst_n)
        reload |-> (half_period != '0)
    );

endmodule

// ==== verilog/emu_pkg.sv ====
package emu_pkg;

    // emulated time quantities, all in picoseconds
    typedef logic [23:0] dt_t;

    // upper bound on a single emulation step
    localparam dt_t DT_MAX = 24'h7f_ffff;

    // phase interpolator delay code
    typedef logic [8:0] code_t;

    // signed jitter offset in picoseconds
    typedef logic signed [7:0] jit_t;

    // one output transition waiting in the delay queue
    // remaining is measured from the entry ahead of it, or from now for the head
    typedef struct packed {
        logic level;
        dt_t  remaining;
    } edge_evt_t;

    // galois feedback mask of the jitter LFSR, right shifting form
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

endpackage
